/* mmr_top.f */
+incdir+verif
design/mmr_pkg.sv
design/reg_wr_if.sv
design/bus_decoder.sv
design/global_regs.sv
design/pcm_dac.sv
design/clk_divider.sv
design/opreg_decode.sv
design/mmr_top.sv
verif/mmr_checker.sv
verif/tb_mmr_top.sv

/* Makefile */
TOOL  = verilator
TOP   = tb_mmr_top
FLIST = mmr_top.f
FLAGS = --binary --timing --timescale 1ns/1ps --top-module $(TOP)
BUILD = obj_dir
LOG   = sim.log
PASS  = PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/chk_groups.svh */
/*
 * Expected-output group codes shared by the testbench and the checker
 */

localparam logic [3:0] G_NOUP  = 4'd0;   // No value, no pulse
localparam logic [3:0] G_TEST  = 4'd1;   // {eg_stop, pg_stop, fast_timers}
localparam logic [3:0] G_LFO   = 4'd2;   // {lfo_en, lfo_freq}
localparam logic [3:0] G_VA    = 4'd3;
localparam logic [3:0] G_VB    = 4'd4;
localparam logic [3:0] G_TIMER = 4'd5;   // Register 27 bits 5..0
localparam logic [3:0] G_CLRA  = 4'd6;   // As G_TIMER, then clr_flag_a must clear
localparam logic [3:0] G_PCM   = 4'd7;   // pcm value plus one pcm_wr pulse
localparam logic [3:0] G_DACT  = 4'd8;   // pcm value, no pulse
localparam logic [3:0] G_PCMEN = 4'd9;
localparam logic [3:0] G_UP    = 4'd10;  // {up_kind, up_ch, up_op}, one up_valid
localparam logic [3:0] G_DIV   = 4'd11;  // div_sel in bits 9..8 and clk_en period in bits 7..0

/* verif/tb_mmr_top.sv */
/*
 * Testbench for the host register block: clock and reset,
 * stimulus table with a random tail, drive loop, timeout, report
 */

module tb_mmr_top;
    timeunit 1ns;
    timeprecision 1ps;

    `include "chk_groups.svh"

    localparam int busy_periods = 32;
    localparam int n_random     = 8;

    typedef struct packed {
        logic        part;
        logic [7:0]  num;
        logic [7:0]  data;
        logic [3:0]  group;
        logic [15:0] val;
        logic [7:0]  wait_cyc;
    } entry_t;

    logic clk, rst, write;
    logic [1:0] addr;
    logic [7:0] din, value_b, up_data;
    logic clk_en, busy, load_a, load_b, enable_irq_a, enable_irq_b;
    logic clr_flag_a, clr_flag_b, fast_timers, lfo_en, eg_stop, pg_stop;
    logic pcm_en, pcm_wr, up_valid;
    logic [9:0] value_a;
    logic [8:0] pcm;
    logic [2:0] lfo_freq, up_ch;
    logic [1:0] up_op;
    mmr_pkg::div_e     div_sel;
    mmr_pkg::up_kind_e up_kind;

    logic [3:0]  exp_group;
    logic [15:0] exp_val;
    logic        run_end;
    logic        end_done;
    int          err_value, err_pulse, err_busy;
    entry_t      stim_q[$];
    int          cycles = 0;
    int          limit;
    integer      seed;

    mmr_top #(.busy_periods(busy_periods)) i_dut (.*);

    mmr_checker #(.busy_periods(busy_periods)) i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] event_fields(input mmr_pkg::up_kind_e kind,
                                                 input logic [2:0] ch, input logic [1:0] op);
        return {7'd0, kind, ch, op};
    endfunction

    task automatic add_entry(input logic part, input logic [7:0] num, input logic [7:0] data,
                             input logic [3:0] group, input logic [15:0] val, input int wait_cyc);
        stim_q.push_back({part, num, data, group, val, 8'(wait_cyc)});
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [7:0]  num;
        add_entry(1'b0, 8'h23, 8'h00, G_DIV, 16'h306, 25);    // Period after reset
        add_entry(1'b0, 8'h21, 8'h2C, G_TEST, 16'h7, 6);
        add_entry(1'b1, 8'h21, 8'h00, G_TEST, 16'h7, 6);     // Part 1 ignored
        add_entry(1'b0, 8'h21, 8'h20, G_TEST, 16'h4, 6);
        add_entry(1'b0, 8'h22, 8'h0D, G_LFO, 16'hD, 6);
        add_entry(1'b1, 8'h22, 8'h00, G_LFO, 16'hD, 6);
        add_entry(1'b0, 8'h24, 8'hA5, G_VA, 16'h294, 6);
        add_entry(1'b0, 8'h25, 8'h03, G_VA, 16'h297, 6);
        add_entry(1'b1, 8'h24, 8'h00, G_VA, 16'h297, 6);
        add_entry(1'b1, 8'h25, 8'h00, G_VA, 16'h297, 6);
        add_entry(1'b1, 8'h26, 8'h5A, G_VB, 16'h5A, 6);     // Either part
        add_entry(1'b0, 8'h26, 8'hC3, G_VB, 16'hC3, 6);
        add_entry(1'b0, 8'h27, 8'h0F, G_TIMER, 16'h0F, 6);
        add_entry(1'b0, 8'h27, 8'h10, G_CLRA, 16'h10, 12);
        add_entry(1'b0, 8'h2A, 8'h80, G_PCM, 16'h001, 6);
        add_entry(1'b0, 8'h2B, 8'h80, G_PCMEN, 16'h1, 6);
        add_entry(1'b0, 8'h2B, 8'h00, G_PCMEN, 16'h0, 6);
        add_entry(1'b0, 8'h2C, 8'h00, G_DACT, 16'h000, 6);
        add_entry(1'b0, 8'h2C, 8'h08, G_DACT, 16'h001, 6);
        add_entry(1'b1, 8'hA1, 8'h12, G_UP, event_fields(mmr_pkg::UP_FNUM_LO, 3'd5, 2'd0), 6);
        add_entry(1'b0, 8'hB5, 8'h34, G_UP, event_fields(mmr_pkg::UP_PMS, 3'd1, 2'd1), 6);
        add_entry(1'b0, 8'h46, 8'h7F, G_UP, event_fields(mmr_pkg::UP_TL, 3'd2, 2'd1), 6);
        add_entry(1'b1, 8'h9C, 8'h0B, G_UP, event_fields(mmr_pkg::UP_SSGEG, 3'd4, 2'd3), 6);
        add_entry(1'b0, 8'h28, 8'hF1, G_UP, event_fields(mmr_pkg::UP_KEYON, 3'd0, 2'd2), 6);
        add_entry(1'b0, 8'hA3, 8'h55, G_NOUP, 16'd0, 6);    // Slot 3, no event
        add_entry(1'b0, 8'h2F, 8'h00, G_DIV, 16'h002, 25);
        add_entry(1'b0, 8'h2E, 8'h00, G_DIV, 16'h103, 25);
        add_entry(1'b0, 8'h2D, 8'h00, G_DIV, 16'h306, 25);
        // Random PCM samples and TL writes
        for (int k = 0; k < n_random; k++) begin
            r   = $random(seed);
            num = {4'h4, r[11:8]};
            if (k % 2 == 0)
                add_entry(1'b0, 8'h2A, r[7:0], G_PCM, {7'd0, ~r[7], r[6:0], 1'b1}, 6);
            else if (num[1:0] == 2'b11)
                add_entry(r[12], num, r[7:0], G_NOUP, 16'd0, 6);
            else
                add_entry(r[12], num, r[7:0], G_UP,
                          event_fields(mmr_pkg::UP_TL, {r[12], num[1:0]}, num[3:2]), 6);
        end
    endtask

    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge clk);
        write <= 1'b1;
        addr  <= a;
        din   <= d;
        @(posedge clk);
        write <= 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        exp_group <= e.group;
        exp_val   <= e.val;
        bus_write({e.part, 1'b0}, e.num);     // Address phase
        bus_write({e.part, 1'b1}, e.data);
        repeat (e.wait_cyc) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Run stopped at the cycle limit of %0d", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        rst       = 1'b1;
        write     = 1'b0;
        addr      = 2'b00;
        din       = 8'h00;
        exp_group = G_NOUP;
        exp_val   = 16'd0;
        run_end   = 1'b0;
        seed      = 32'h9247_687b;
        build_table();
        limit = 16 + stim_q.size() * (busy_periods * 6 + 20);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        foreach (stim_q[i])
            apply_entry(stim_q[i]);
        repeat (busy_periods * 6 + 20) @(posedge clk);    // Let busy run out
        run_end <= 1'b1;
        while (!end_done)
            @(posedge clk);
        $display("Errors: value %0d, pulse %0d, busy %0d", err_value, err_pulse, err_busy);
        if (err_value + err_pulse + err_busy == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verif/mmr_checker.sv */
/*
 * Checker for the host register block: register values two cycles
 * after each data write, pulse counts, clk_en period and busy length
 */

module mmr_checker #(
    parameter int busy_periods = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                write,
    input  logic [1:0]          addr,
    input  logic [7:0]          din,
    input  logic                clk_en,
    input  logic                busy,
    input  mmr_pkg::div_e       div_sel,
    input  logic [9:0]          value_a,
    input  logic [7:0]          value_b,
    input  logic                load_a,
    input  logic                load_b,
    input  logic                enable_irq_a,
    input  logic                enable_irq_b,
    input  logic                clr_flag_a,
    input  logic                clr_flag_b,
    input  logic                fast_timers,
    input  logic                lfo_en,
    input  logic [2:0]          lfo_freq,
    input  logic                eg_stop,
    input  logic                pg_stop,
    input  logic [8:0]          pcm,
    input  logic                pcm_en,
    input  logic                pcm_wr,
    input  logic                up_valid,
    input  mmr_pkg::up_kind_e   up_kind,
    input  logic [2:0]          up_ch,
    input  logic [1:0]          up_op,
    input  logic [7:0]          up_data,
    input  logic [3:0]          exp_group,
    input  logic [15:0]         exp_val,
    input  logic                run_end,
    output int                  err_value,
    output int                  err_pulse,
    output int                  err_busy,
    output logic                end_done
);
    timeunit 1ns;
    timeprecision 1ps;

    `include "chk_groups.svh"

    int   cen_seen;     // clk_en pulses since the last data write
    int   falls;
    logic busy_q;
    logic wr_seen;

    function automatic logic [15:0] observed(input logic [3:0] grp);
        case (grp)
            G_TEST:          return {13'd0, eg_stop, pg_stop, fast_timers};
            G_LFO:           return {12'd0, lfo_en, lfo_freq};
            G_VA:            return {6'd0, value_a};
            G_VB:            return {8'd0, value_b};
            G_TIMER, G_CLRA: return {10'd0, clr_flag_b, clr_flag_a, enable_irq_b,
                                     enable_irq_a, load_b, load_a};
            G_PCM, G_DACT:   return {7'd0, pcm};
            G_PCMEN:         return {15'd0, pcm_en};
            G_UP:            return {7'd0, up_kind, up_ch, up_op};
            default:         return 16'd0;
        endcase
    endfunction

    function automatic string signal_name(input logic [3:0] grp);
        case (grp)
            G_TEST:          return "{eg_stop,pg_stop,fast_timers}";
            G_LFO:           return "{lfo_en,lfo_freq}";
            G_VA:            return "value_a";
            G_VB:            return "value_b";
            G_TIMER, G_CLRA: return {"{clr_flag_b,clr_flag_a,enable_irq_b,",
                                     "enable_irq_a,load_b,load_a}"};
            G_PCM, G_DACT:   return "pcm";
            G_PCMEN:         return "pcm_en";
            default:         return "{up_kind,up_ch,up_op}";
        endcase
    endfunction

    task automatic wait_cen();
        do
            @(posedge clk);
        while (!clk_en);
    endtask

    // Runs from the data-write edge E to the end of its checks
    task automatic check_entry();
        logic [3:0]  grp;
        logic [15:0] val;
        logic [7:0]  data;
        int          n_pcm;
        int          n_up;
        int          per;
        grp   = exp_group;
        val   = exp_val;
        data  = din;
        n_pcm = 0;
        n_up  = 0;
        for (int i = 1; i <= 4; i++) begin
            @(posedge clk);
            if (pcm_wr)
                n_pcm++;
            if (up_valid)
                n_up++;
            if (i == 2 && grp != G_NOUP && grp != G_DIV && observed(grp) != val) begin
                $display("mismatch %s: got %h, expected %h", signal_name(grp), observed(grp), val);
                err_value++;
            end
            if (i == 2 && grp == G_UP && up_data != data) begin
                $display("mismatch up_data: got %h, expected %h", up_data, data);
                err_value++;
            end
            if (i == 2 && grp == G_DIV && div_sel != val[9:8]) begin
                $display("mismatch div_sel: got %h, expected %h", div_sel, val[9:8]);
                err_value++;
            end
        end
        if (n_pcm != ((grp == G_PCM) ? 1 : 0) || n_up != ((grp == G_UP) ? 1 : 0)) begin
            $display("Wrong pulse count after writing %h: pcm_wr %0d, up_valid %0d", data,
                     n_pcm, n_up);
            err_pulse++;
        end
        if (grp == G_CLRA) begin
            while (!clk_en)
                @(posedge clk);
            @(posedge clk);
            if (clr_flag_a) begin
                $display("clr_flag_a is still set after a clk_en without a write");
                err_pulse++;
            end
        end
        if (grp == G_DIV) begin
            wait_cen();
            wait_cen();    // New period runs from here
            per = 0;
            do begin
                @(posedge clk);
                per++;
            end while (!clk_en);
            if (per != int'(val[7:0])) begin
                $display("mismatch clk_en period: got %h, expected %h", per, val[7:0]);
                err_value++;
            end
        end
    endtask

    initial begin
        err_value = 0;
        err_pulse = 0;
        forever begin
            @(posedge clk);
            if (!rst && write && addr[0])
                check_entry();
        end
    end

    // Busy set and busy length
    always @(posedge clk) begin
        if (rst) begin
            cen_seen <= 0;
            falls    <= 0;
            busy_q   <= 1'b0;
            wr_seen  <= 1'b0;
            err_busy <= 0;
            end_done <= 1'b0;
        end else begin
            busy_q  <= busy;
            wr_seen <= write && addr[0];
            if (write && addr[0])
                cen_seen <= 0;
            else if (clk_en && busy)
                cen_seen <= cen_seen + 1;
            if (wr_seen && !busy) begin
                $display("busy was not set in the cycle after a data write");
                err_busy <= err_busy + 1;
            end
            if (busy_q && !busy) begin
                falls <= falls + 1;
                if (cen_seen != busy_periods) begin
                    $display("busy fell after %0d clk_en pulses instead of %0d", cen_seen,
                             busy_periods);
                    err_busy <= err_busy + 1;
                end
            end
            if (run_end && !end_done) begin
                if (falls == 0) begin
                    $display("busy never fell during the run");
                    err_busy <= err_busy + 1;
                end
                end_done <= 1'b1;
            end
        end
    end

endmodule

/* design/mmr_top.sv */
/*
 * Top of the host register block: bus decoder, global and
 * PCM registers, update decoder and clock divider
 */

module mmr_top #(
    parameter int busy_periods = 32,
    parameter int use_pcm      = 1
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [mmr_pkg::data_w-1:0]    din,
    input  logic                          write,
    input  logic [1:0]                    addr,
    output logic                          clk_en,
    output logic                          busy,
    output mmr_pkg::div_e                 div_sel,
    output logic [mmr_pkg::timer_a_w-1:0] value_a,
    output logic [mmr_pkg::data_w-1:0]    value_b,
    output logic                          load_a,
    output logic                          load_b,
    output logic                          enable_irq_a,
    output logic                          enable_irq_b,
    output logic                          clr_flag_a,
    output logic                          clr_flag_b,
    output logic                          fast_timers,
    output logic                          lfo_en,
    output logic [2:0]                    lfo_freq,
    output logic                          eg_stop,
    output logic                          pg_stop,
    output logic [8:0]                    pcm,
    output logic                          pcm_en,
    output logic                          pcm_wr,
    output logic                          up_valid,
    output mmr_pkg::up_kind_e             up_kind,
    output logic [2:0]                    up_ch,
    output logic [1:0]                    up_op,
    output logic [mmr_pkg::data_w-1:0]    up_data
);

    reg_wr_if u_wr ();

    bus_decoder #(
        .busy_periods (busy_periods)
    ) u_bus (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .write  (write),
        .addr   (addr),
        .clk_en (clk_en),
        .wr     (u_wr),
        .busy   (busy)
    );

    global_regs u_glob (
        .clk          (clk),
        .rst          (rst),
        .clk_en       (clk_en),
        .wr           (u_wr),
        .div_sel      (div_sel),
        .value_a      (value_a),
        .value_b      (value_b),
        .load_a       (load_a),
        .load_b       (load_b),
        .enable_irq_a (enable_irq_a),
        .enable_irq_b (enable_irq_b),
        .clr_flag_a   (clr_flag_a),
        .clr_flag_b   (clr_flag_b),
        .fast_timers  (fast_timers),
        .lfo_en       (lfo_en),
        .lfo_freq     (lfo_freq),
        .eg_stop      (eg_stop),
        .pg_stop      (pg_stop)
    );

    if (use_pcm != 0) begin : g_pcm
        pcm_dac u_pcm (
            .clk    (clk),
            .rst    (rst),
            .clk_en (clk_en),
            .wr     (u_wr),
            .pcm    (pcm),
            .pcm_en (pcm_en),
            .pcm_wr (pcm_wr)
        );
    end else begin : g_no_pcm
        assign pcm    = 9'd0;   // Chip variant without DAC
        assign pcm_en = 1'b0;
        assign pcm_wr = 1'b0;
    end

    opreg_decode u_opreg (
        .clk      (clk),
        .rst      (rst),
        .wr       (u_wr),
        .up_valid (up_valid),
        .up_kind  (up_kind),
        .up_ch    (up_ch),
        .up_op    (up_op),
        .up_data  (up_data)
    );

    clk_divider u_div (
        .clk     (clk),
        .rst     (rst),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

endmodule

/* design/opreg_decode.sv */
/*
 * Channel and operator register decoder, turns data writes
 * into update events for the per-channel register file
 */

module opreg_decode (
    input  logic                       clk,
    input  logic                       rst,
    reg_wr_if.dst                      wr,
    output logic                       up_valid,
    output mmr_pkg::up_kind_e          up_kind,
    output logic [2:0]                 up_ch,
    output logic [1:0]                 up_op,
    output logic [mmr_pkg::data_w-1:0] up_data
);

    mmr_pkg::up_kind_e kind;

    always_comb begin
        kind = mmr_pkg::UP_NONE;
        if (wr.sel == mmr_pkg::REG_KON && !wr.part)
            kind = mmr_pkg::UP_KEYON;
        else if (wr.sel[1:0] != 2'b11) begin    // Slot 3 does not exist
            case (wr.sel[7:4])
                4'h3: kind = mmr_pkg::UP_DT1;
                4'h4: kind = mmr_pkg::UP_TL;
                4'h5: kind = mmr_pkg::UP_KS_AR;
                4'h6: kind = mmr_pkg::UP_AMEN_DR;
                4'h7: kind = mmr_pkg::UP_SR;
                4'h8: kind = mmr_pkg::UP_SL_RR;
                4'h9: kind = mmr_pkg::UP_SSGEG;
                4'hA: if (wr.sel[3:2] == 2'b00) kind = mmr_pkg::UP_FNUM_LO;
                4'hB: begin
                    if (wr.sel[3:2] == 2'b00)
                        kind = mmr_pkg::UP_ALG;
                    else if (wr.sel[3:2] == 2'b01)
                        kind = mmr_pkg::UP_PMS;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            up_valid <= 1'b0;
            up_kind  <= mmr_pkg::UP_NONE;
        end else begin
            up_valid <= wr.valid && (kind != mmr_pkg::UP_NONE);
            up_kind  <= wr.valid ? kind : mmr_pkg::UP_NONE;
        end
    end

    // Payload follows the event
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            up_ch   <= {wr.part, wr.sel[1:0]};
            up_op   <= wr.sel[3:2];             // 0=S1 1=S3 2=S2 3=S4
            up_data <= wr.data;
        end
    end

    a_kind_known : assert property (@(posedge clk) disable iff (rst)
        up_valid |-> up_kind != mmr_pkg::UP_NONE);

endmodule

/* design/clk_divider.sv */
/*
 * Master clock-enable generator, period 6, 3 or 2
 * clocks as picked by the prescaler registers
 */

module clk_divider (
    input  logic          clk,
    input  logic          rst,
    input  mmr_pkg::div_e div_sel,
    output logic          clk_en
);

    logic [2:0] cnt;
    logic [2:0] reload;

    // Reload is period minus one
    always_comb begin
        case (div_sel)
            mmr_pkg::DIV_2: reload = 3'd1;
            mmr_pkg::DIV_3: reload = 3'd2;
            default:        reload = 3'd5;  // /6, also for code 10
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            cnt <= 3'd5;
        else if (cnt == 3'd0)
            cnt <= reload;          // New period starts here
        else
            cnt <= cnt - 3'd1;
    end

    assign clk_en = (cnt == 3'd0);

    a_cen_single : assert property (@(posedge clk) disable iff (rst)
        clk_en |=> !clk_en);

endmodule

/* design/pcm_dac.sv */
/*
 * PCM DAC sample register with enable and
 * single-cycle write pulse
 */

module pcm_dac (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    reg_wr_if.dst      wr,
    output logic [8:0] pcm,
    output logic       pcm_en,
    output logic       pcm_wr
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pcm    <= 9'd0;
            pcm_en <= 1'b0;
            pcm_wr <= 1'b0;
        end else begin
            pcm_wr <= wr.valid && (wr.sel == mmr_pkg::REG_PCM);
            if (wr.valid) begin
                case (wr.sel)
                    mmr_pkg::REG_PCM:     pcm <= {~wr.data[7], wr.data[6:0], 1'b1}; // Offset binary
                    mmr_pkg::REG_PCM_EN:  pcm_en <= wr.data[7];
                    mmr_pkg::REG_DACTEST: pcm[0] <= wr.data[3];    // Extra LSB
                    default: ;
                endcase
            end
        end
    end

endmodule

/* design/global_regs.sv */
/*
 * Global control registers: test stops, LFO, timer A/B values
 * and control, one-shot timer flag clears, clock divider select
 */

module global_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clk_en,
    reg_wr_if.dst                         wr,
    output mmr_pkg::div_e                 div_sel,
    output logic [mmr_pkg::timer_a_w-1:0] value_a,
    output logic [mmr_pkg::data_w-1:0]    value_b,
    output logic                          load_a,
    output logic                          load_b,
    output logic                          enable_irq_a,
    output logic                          enable_irq_b,
    output logic                          clr_flag_a,
    output logic                          clr_flag_b,
    output logic                          fast_timers,
    output logic                          lfo_en,
    output logic [2:0]                    lfo_freq,
    output logic                          eg_stop,
    output logic                          pg_stop
);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_sel      <= mmr_pkg::DIV_6;
            value_a      <= '0;
            value_b      <= '0;
            {clr_flag_b, clr_flag_a} <= 2'b00;
            {enable_irq_b, enable_irq_a} <= 2'b00;
            {load_b, load_a} <= 2'b00;
            fast_timers  <= 1'b0;
            lfo_en       <= 1'b0;
            lfo_freq     <= 3'd0;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
        end else if (wr.valid) begin
            case (wr.sel)
                mmr_pkg::REG_TEST: begin
                    if (!wr.part) begin
                        eg_stop     <= wr.data[5];
                        pg_stop     <= wr.data[3];
                        fast_timers <= wr.data[2];
                    end
                end
                mmr_pkg::REG_LFO:
                    if (!wr.part) {lfo_en, lfo_freq} <= wr.data[3:0];
                mmr_pkg::REG_CLKA1:
                    if (!wr.part) value_a[mmr_pkg::timer_a_w-1:2] <= wr.data;
                mmr_pkg::REG_CLKA2:
                    if (!wr.part) value_a[1:0] <= wr.data[1:0];
                mmr_pkg::REG_CLKB:  value_b <= wr.data;    // Either part
                mmr_pkg::REG_TIMER: begin
                    {clr_flag_b, clr_flag_a,
                     enable_irq_b, enable_irq_a,
                     load_b, load_a} <= wr.data[5:0];
                end
                // Prescaler bits accumulate, 2F drops back to /2
                mmr_pkg::REG_CLK_N6: div_sel <= mmr_pkg::div_e'({1'b1, div_sel[0]});
                mmr_pkg::REG_CLK_N3: div_sel <= mmr_pkg::div_e'({div_sel[1], 1'b1});
                mmr_pkg::REG_CLK_N2: div_sel <= mmr_pkg::DIV_2;
                default: ;
            endcase
        end else if (clk_en) begin
            clr_flag_a <= 1'b0;     // Flag clears are one-shot
            clr_flag_b <= 1'b0;
        end
    end

    // Timer block sees each clear on at least one clock-enable
    a_clr_on_cen : assert property (@(posedge clk) disable iff (rst)
        ($fell(clr_flag_a) || $fell(clr_flag_b)) |-> $past(clk_en));

endmodule

/* design/bus_decoder.sv */
/*
 * Host bus front end: address latch, part select,
 * data write event and the advisory busy timer
 */

module bus_decoder #(
    parameter int busy_periods = 32
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mmr_pkg::data_w-1:0] din,
    input  logic                       write,
    input  logic [1:0]                 addr,
    input  logic                       clk_en,
    reg_wr_if.src                      wr,
    output logic                       busy
);

    localparam int cnt_w = $clog2(busy_periods + 1);

    logic             old_write;
    logic             data_wr;
    logic [cnt_w-1:0] busy_cnt;

    assign data_wr = write && addr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            old_write <= 1'b0;
            wr.valid  <= 1'b0;
            wr.sel    <= '0;
            wr.part   <= 1'b0;
        end else begin
            old_write <= write;
            wr.valid  <= data_wr;       // One cycle after the data strobe
            if (write && !addr[0]) begin
                wr.sel  <= din;         // Address phase
                wr.part <= addr[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr)
            wr.data <= din;
    end

    // Busy spans busy_periods clock-enable pulses after each data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr && !old_write) begin
            busy     <= 1'b1;
            busy_cnt <= '0;             // Restart on a new write
        end else if (clk_en && busy) begin
            if (busy_cnt == cnt_w'(busy_periods - 1))
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    // Host strobes are single cycle, so events never merge
    a_valid_single : assert property (@(posedge clk) disable iff (rst)
        wr.valid |=> !wr.valid);

endmodule

/* design/reg_wr_if.sv */
/*
 * Decoded register write, one cycle per host data write
 * src side is the bus decoder, dst side every register sink
 */

interface reg_wr_if;

    logic                       valid;  // Single-cycle write event
    logic                       part;   // Register bank, from addr[1]
    logic [mmr_pkg::data_w-1:0] sel;    // Latched register number
    logic [mmr_pkg::data_w-1:0] data;

    // No ready, every sink takes the write in the valid cycle
    modport src (
        output valid, part, sel, data
    );

    modport dst (
        input valid, part, sel, data
    );

endinterface

/* design/mmr_pkg.sv */
/*
 * Shared widths and encodings of the FM host register block:
 * global register numbers, update-event kinds, clock divider selection
 */

package mmr_pkg;

    localparam int data_w    = 8;   // Data byte and register number
    localparam int timer_a_w = 10;

    // Global register map, part 0 unless noted in the sinks
    typedef enum logic [7:0] {
        REG_TEST    = 8'h21,
        REG_LFO     = 8'h22,
        REG_CLKA1   = 8'h24,
        REG_CLKA2   = 8'h25,
        REG_CLKB    = 8'h26,
        REG_TIMER   = 8'h27,
        REG_KON     = 8'h28,
        REG_PCM     = 8'h2A,
        REG_PCM_EN  = 8'h2B,
        REG_DACTEST = 8'h2C,
        REG_CLK_N6  = 8'h2D,
        REG_CLK_N3  = 8'h2E,
        REG_CLK_N2  = 8'h2F
    } reg_num_e;

    // Kind of per-channel / per-operator update
    typedef enum logic [3:0] {
        UP_NONE,
        UP_FNUM_LO,
        UP_ALG,
        UP_PMS,
        UP_DT1,
        UP_TL,
        UP_KS_AR,
        UP_AMEN_DR,
        UP_SR,
        UP_SL_RR,
        UP_SSGEG,
        UP_KEYON
    } up_kind_e;

    // Code 2'b10 is not listed and divides by 6 as well
    typedef enum logic [1:0] {
        DIV_2 = 2'b00,
        DIV_3 = 2'b01,
        DIV_6 = 2'b11
    } div_e;

endpackage
